// ==== files.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_ifs.sv
hw/lsu_pipe.sv
hw/lsu_store_buffer.sv
hw/lsu_dcache.sv
hw/lsu_top.sv
tests/tb_clock_gen.sv
tests/lsu_assert.sv
tests/tb_lsu_top.sv

// ==== hw/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data word width in bits
`define LSU_DATA_W 32

// Byte address width, 64 words of 32 bits
`define LSU_ADDR_W 8

// Store buffer entries, power of two
`define LSU_STBUF_DEPTH 4

// Request tag width
`define LSU_TAG_W 4

`endif

// ==== hw/lsu_dcache.sv ====
`include "lsu_config.svh"

module lsu_dcache (
  input  logic           i_clk,
  input  logic           i_reset_n,
  dcache_rd_if.responder rd_pipe,
  dcache_rd_if.responder rd_snoop,
  dcache_wr_if.sink      wr
);

  localparam int BYTES = `LSU_DATA_W / 8;
  localparam int OFF_W = $clog2(BYTES);
  localparam int WORDS = (1 << `LSU_ADDR_W) / BYTES;
  localparam int IDX_W = $clog2(WORDS);

  logic [`LSU_DATA_W-1:0] r_mem [WORDS];

  logic [IDX_W-1:0]       w_wr_idx;
  logic [IDX_W-1:0]       w_pipe_idx;
  logic [IDX_W-1:0]       w_snoop_idx;
  logic [`LSU_DATA_W-1:0] w_wr_word;

  assign w_wr_idx    = wr.addr[`LSU_ADDR_W-1:OFF_W];
  assign w_pipe_idx  = rd_pipe.s0_addr[`LSU_ADDR_W-1:OFF_W];
  assign w_snoop_idx = rd_snoop.s0_addr[`LSU_ADDR_W-1:OFF_W];

  // Word as it looks after this cycle's write
  assign w_wr_word = lsu_pkg::merge_bytes(r_mem[w_wr_idx], wr.strb, wr.data);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < WORDS; i++) begin
        r_mem[i] <= '0;
      end
    end else if (wr.valid) begin
      r_mem[w_wr_idx] <= w_wr_word;
    end
  end

  // ------------------------------------------------------------
  // Read ports, write-first on a same-word hit
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      rd_pipe.s1_valid  <= 1'b0;
      rd_snoop.s1_valid <= 1'b0;
    end else begin
      rd_pipe.s1_valid  <= rd_pipe.s0_valid;
      rd_snoop.s1_valid <= rd_snoop.s0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_pipe.s1_data  <= (wr.valid && (w_wr_idx == w_pipe_idx)) ? w_wr_word
                                                               : r_mem[w_pipe_idx];
    rd_snoop.s1_data <= (wr.valid && (w_wr_idx == w_snoop_idx)) ? w_wr_word
                                                                : r_mem[w_snoop_idx];
  end

endmodule

// ==== hw/lsu_ifs.sv ====
`include "lsu_config.svh"

// Cache read port, data returns one cycle after s0
interface dcache_rd_if;
  logic                   s0_valid;
  logic [`LSU_ADDR_W-1:0] s0_addr;
  logic                   s1_valid;
  logic [`LSU_DATA_W-1:0] s1_data;

  modport requester (output s0_valid, s0_addr, input s1_valid, s1_data);
  modport responder (input s0_valid, s0_addr, output s1_valid, s1_data);
endinterface

// One strobe per store entering the store buffer
interface stbuf_push_if;
  logic                     valid;
  logic [`LSU_ADDR_W-1:0]   addr;
  logic [`LSU_DATA_W-1:0]   data;
  logic [`LSU_DATA_W/8-1:0] strb;

  modport source (output valid, addr, data, strb);
  modport sink   (input valid, addr, data, strb);
endinterface

// Same-cycle forwarding lookup into the store buffer
interface fwd_check_if;
  logic                     valid;
  logic [`LSU_ADDR_W-1:0]   addr;
  logic                     hit;
  logic [`LSU_DATA_W/8-1:0] data_strb;
  logic [`LSU_DATA_W-1:0]   data;

  modport requester (output valid, addr, input hit, data_strb, data);
  modport responder (input valid, addr, output hit, data_strb, data);
endinterface

// Byte-strobed cache write, taken at the clock edge
interface dcache_wr_if;
  logic                     valid;
  logic [`LSU_ADDR_W-1:0]   addr;
  logic [`LSU_DATA_W-1:0]   data;
  logic [`LSU_DATA_W/8-1:0] strb;

  modport source (output valid, addr, data, strb);
  modport sink   (input valid, addr, data, strb);
endinterface

// ==== hw/lsu_pipe.sv ====
`include "lsu_config.svh"

module lsu_pipe (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_req_valid,
  input  lsu_pkg::lsu_op_e                    i_req_op,
  input  logic [`LSU_ADDR_W-1:0]              i_req_addr,
  input  logic [`LSU_DATA_W-1:0]              i_req_data,
  input  logic [`LSU_TAG_W-1:0]               i_req_tag,
  output logic                                o_req_ready,
  dcache_rd_if.requester                      rd,
  stbuf_push_if.source                        push,
  fwd_check_if.requester                      fwd,
  input  logic [$clog2(`LSU_STBUF_DEPTH):0]   i_stbuf_count,
  output lsu_pkg::done_rpt_t                  o_done
);

  localparam int BYTES = `LSU_DATA_W / 8;
  localparam int OFF_W = $clog2(BYTES);
  localparam int CNT_W = $clog2(`LSU_STBUF_DEPTH) + 1;

  logic                   w_accept;
  logic [BYTES-1:0]       w_st_strb;
  logic [`LSU_DATA_W-1:0] w_st_data;

  logic                   r_s2_valid;
  lsu_pkg::lsu_op_e       r_s2_op;
  logic [`LSU_ADDR_W-1:0] r_s2_addr;
  logic [`LSU_DATA_W-1:0] r_s2_data;
  logic [BYTES-1:0]       r_s2_strb;
  logic [`LSU_TAG_W-1:0]  r_s2_tag;

  logic                   w_s2_load;
  logic                   w_s2_store;
  logic [`LSU_DATA_W-1:0] w_ld_data;

  // ------------------------------------------------------------
  // Stage 1: accept, cache read, store expansion
  // ------------------------------------------------------------
  // A store already in stage 2 still needs a buffer slot
  assign o_req_ready = (i_stbuf_count + CNT_W'(w_s2_store)) < CNT_W'(`LSU_STBUF_DEPTH);
  assign w_accept    = i_req_valid & o_req_ready;

  assign rd.s0_valid = w_accept && (i_req_op == lsu_pkg::OP_LW);
  assign rd.s0_addr  = i_req_addr;

  always_comb begin
    w_st_strb = '0;
    w_st_data = i_req_data;
    case (i_req_op)
      lsu_pkg::OP_SW: w_st_strb = '1;
      lsu_pkg::OP_SB: begin
        w_st_strb = BYTES'(1) << i_req_addr[OFF_W-1:0];
        w_st_data = {BYTES{i_req_data[7:0]}};
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s2_valid <= 1'b0;
    end else begin
      r_s2_valid <= w_accept;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s2_op   <= i_req_op;
    r_s2_addr <= i_req_addr;
    r_s2_data <= w_st_data;
    r_s2_strb <= w_st_strb;
    r_s2_tag  <= i_req_tag;
  end

  // ------------------------------------------------------------
  // Stage 2: push stores, merge forwarded bytes into loads
  // ------------------------------------------------------------
  assign w_s2_load  = r_s2_valid && (r_s2_op == lsu_pkg::OP_LW);
  assign w_s2_store = r_s2_valid && (r_s2_op != lsu_pkg::OP_LW);

  assign push.valid = w_s2_store;
  assign push.addr  = r_s2_addr;
  assign push.data  = r_s2_data;
  assign push.strb  = r_s2_strb;

  assign fwd.valid = w_s2_load;
  assign fwd.addr  = r_s2_addr;

  // Younger buffered bytes win over the cache word
  assign w_ld_data = fwd.hit ? lsu_pkg::merge_bytes(rd.s1_data, fwd.data_strb, fwd.data)
                             : rd.s1_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done <= '0;
    end else begin
      o_done.valid   <= r_s2_valid;
      o_done.tag     <= r_s2_tag;
      o_done.is_load <= w_s2_load;
      o_done.data    <= (w_s2_load && rd.s1_valid) ? w_ld_data : '0;
    end
  end

endmodule

// ==== hw/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    OP_LW,
    OP_SW,
    OP_SB
  } lsu_op_e;

  typedef struct packed {
    logic                   valid;
    logic [`LSU_TAG_W-1:0]  tag;
    logic                   is_load;
    logic [`LSU_DATA_W-1:0] data;
  } done_rpt_t;

  // Replace the bytes of base that are enabled in strb
  function automatic logic [`LSU_DATA_W-1:0] merge_bytes(
    input logic [`LSU_DATA_W-1:0]   base,
    input logic [`LSU_DATA_W/8-1:0] strb,
    input logic [`LSU_DATA_W-1:0]   upd
  );
    logic [`LSU_DATA_W-1:0] res;
    res = base;
    for (int b = 0; b < `LSU_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = upd[b*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== hw/lsu_store_buffer.sv ====
`include "lsu_config.svh"

module lsu_store_buffer (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  stbuf_push_if.sink                          push,
  fwd_check_if.responder                      fwd,
  dcache_wr_if.source                         wr,
  input  logic                                i_drain_hold,
  output logic [$clog2(`LSU_STBUF_DEPTH):0]   o_count
);

  localparam int DEPTH = `LSU_STBUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int BYTES = `LSU_DATA_W / 8;
  localparam int OFF_W = $clog2(BYTES);

  // Entry payload
  logic [`LSU_ADDR_W-1:0] r_addr [DEPTH];
  logic [`LSU_DATA_W-1:0] r_data [DEPTH];
  logic [BYTES-1:0]       r_strb [DEPTH];

  logic [PTR_W-1:0]       r_head;
  logic [PTR_W-1:0]       r_tail;
  logic [CNT_W-1:0]       r_count;

  logic                   w_pop;
  logic [`LSU_DATA_W-1:0] w_fwd_data;
  logic [BYTES-1:0]       w_fwd_strb;

  assign o_count = r_count;

  // ------------------------------------------------------------
  // Queue pointers
  // ------------------------------------------------------------
  assign w_pop = (r_count != '0) && !i_drain_hold;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (push.valid) begin
        r_tail <= r_tail + 1'b1;
      end
      if (w_pop) begin
        r_head <= r_head + 1'b1;
      end
      r_count <= r_count + CNT_W'(push.valid) - CNT_W'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push.valid) begin
      r_addr[r_tail] <= push.addr;
      r_data[r_tail] <= push.data;
      r_strb[r_tail] <= push.strb;
    end
  end

  // ------------------------------------------------------------
  // Forwarding search
  // ------------------------------------------------------------
  // Walk oldest to youngest so later stores overwrite earlier bytes
  always_comb begin
    logic [PTR_W-1:0] idx;
    w_fwd_data = '0;
    w_fwd_strb = '0;
    for (int k = 0; k < DEPTH; k++) begin
      idx = r_head + PTR_W'(k);
      if (fwd.valid && (CNT_W'(k) < r_count) &&
          (r_addr[idx][`LSU_ADDR_W-1:OFF_W] == fwd.addr[`LSU_ADDR_W-1:OFF_W])) begin
        w_fwd_data = lsu_pkg::merge_bytes(w_fwd_data, r_strb[idx], r_data[idx]);
        w_fwd_strb = w_fwd_strb | r_strb[idx];
      end
    end
  end

  assign fwd.hit       = |w_fwd_strb;
  assign fwd.data_strb = w_fwd_strb;
  assign fwd.data      = w_fwd_data;

  // ------------------------------------------------------------
  // Drain head entry into the cache
  // ------------------------------------------------------------
  assign wr.valid = w_pop;
  assign wr.addr  = r_addr[r_head];
  assign wr.data  = r_data[r_head];
  assign wr.strb  = r_strb[r_head];

endmodule

// ==== hw/lsu_top.sv ====
`include "lsu_config.svh"

module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_req_valid,
  input  lsu_pkg::lsu_op_e       i_req_op,
  input  logic [`LSU_ADDR_W-1:0] i_req_addr,
  input  logic [`LSU_DATA_W-1:0] i_req_data,
  input  logic [`LSU_TAG_W-1:0]  i_req_tag,
  input  logic                   i_drain_hold,
  input  logic                   i_snoop_valid,
  input  logic [`LSU_ADDR_W-1:0] i_snoop_addr,
  output logic                   o_req_ready,
  output logic                   o_done_valid,
  output logic [`LSU_TAG_W-1:0]  o_done_tag,
  output logic                   o_done_is_load,
  output logic [`LSU_DATA_W-1:0] o_done_data,
  output logic                   o_snoop_valid,
  output logic [`LSU_DATA_W-1:0] o_snoop_data
);

  dcache_rd_if  pipe_rd ();
  dcache_rd_if  snoop_rd ();
  stbuf_push_if stbuf_push ();
  fwd_check_if  fwd_check ();
  dcache_wr_if  dcache_wr ();

  logic [$clog2(`LSU_STBUF_DEPTH):0] w_stbuf_count;
  lsu_pkg::done_rpt_t                w_done;

  lsu_pipe u_lsu_pipe (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_req_valid),
    .i_req_op      (i_req_op),
    .i_req_addr    (i_req_addr),
    .i_req_data    (i_req_data),
    .i_req_tag     (i_req_tag),
    .o_req_ready   (o_req_ready),
    .rd            (pipe_rd),
    .push          (stbuf_push),
    .fwd           (fwd_check),
    .i_stbuf_count (w_stbuf_count),
    .o_done        (w_done)
  );

  lsu_store_buffer u_lsu_store_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .push         (stbuf_push),
    .fwd          (fwd_check),
    .wr           (dcache_wr),
    .i_drain_hold (i_drain_hold),
    .o_count      (w_stbuf_count)
  );

  lsu_dcache u_lsu_dcache (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .rd_pipe   (pipe_rd),
    .rd_snoop  (snoop_rd),
    .wr        (dcache_wr)
  );

  // Snoop reads go straight to the cache, never through the buffer
  assign snoop_rd.s0_valid = i_snoop_valid;
  assign snoop_rd.s0_addr  = i_snoop_addr;
  assign o_snoop_valid     = snoop_rd.s1_valid;
  assign o_snoop_data      = snoop_rd.s1_data;

  assign o_done_valid   = w_done.valid;
  assign o_done_tag     = w_done.tag;
  assign o_done_is_load = w_done.is_load;
  assign o_done_data    = w_done.data;

endmodule

// ==== tests/lsu_assert.sv ====
`include "lsu_config.svh"

module lsu_assert (
  input logic                   i_clk,
  input logic                   i_reset_n,
  input logic                   i_req_valid,
  input logic                   o_req_ready,
  input logic                   o_done_valid,
  input logic                   o_done_is_load,
  input logic [`LSU_DATA_W-1:0] o_done_data,
  input logic                   i_snoop_valid,
  input logic                   o_snoop_valid
);

  int unsigned fail_count = 0;

  // Done strobe two cycles after every accepted request
  a_done_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid == $past(i_req_valid && o_req_ready, 2))
  else begin
    fail_count++;
    $error("o_done_valid does not match the request accepted two cycles earlier");
  end

  // Snoop response one cycle after the request
  a_snoop_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_valid == $past(i_snoop_valid))
  else begin
    fail_count++;
    $error("o_snoop_valid does not follow i_snoop_valid by one cycle");
  end

  a_load_data_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_is_load |-> !$isunknown(o_done_data))
  else begin
    fail_count++;
    $error("load done report carries unknown data");
  end

endmodule

bind lsu_top lsu_assert u_lsu_assert (.*);

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  // Period of 10 time units
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset held for five cycles, released on a falling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (5) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

// ==== tests/tb_lsu_top.sv ====
`include "lsu_config.svh"

module tb_lsu_top;

  localparam int BYTES          = `LSU_DATA_W / 8;
  localparam int OFF_W          = $clog2(BYTES);
  localparam int WORDS          = (1 << `LSU_ADDR_W) / BYTES;
  localparam int N_RAND         = 300;
  // Directed tests plus eight cycles per random step for a drained snoop
  localparam int TEST_CYCLES    = 120 + 8 * N_RAND;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_req_valid;
  lsu_pkg::lsu_op_e       i_req_op;
  logic [`LSU_ADDR_W-1:0] i_req_addr;
  logic [`LSU_DATA_W-1:0] i_req_data;
  logic [`LSU_TAG_W-1:0]  i_req_tag;
  logic                   i_drain_hold;
  logic                   i_snoop_valid;
  logic [`LSU_ADDR_W-1:0] i_snoop_addr;
  logic                   o_req_ready;
  logic                   o_done_valid;
  logic [`LSU_TAG_W-1:0]  o_done_tag;
  logic                   o_done_is_load;
  logic [`LSU_DATA_W-1:0] o_done_data;
  logic                   o_snoop_valid;
  logic [`LSU_DATA_W-1:0] o_snoop_data;

  logic [`LSU_DATA_W-1:0] ref_mem [WORDS];
  lsu_pkg::done_rpt_t     exp_q [$];
  int                     cyc_q [$];
  logic [`LSU_ADDR_W-1:0] touched_q [$];
  logic [`LSU_TAG_W-1:0]  next_tag = '0;
  int                     cyc = 0;
  int                     n_err = 0;
  integer                 seed = 32'hf10c;

  tb_clock_gen u_tb_clock_gen (.o_clk(i_clk), .o_reset_n(i_reset_n));

  lsu_top u_lsu_top (.*);

  // ------------------------------------------------------------
  // Reference memory in program order
  // ------------------------------------------------------------
  function automatic logic [`LSU_DATA_W-1:0] ref_access(input lsu_pkg::lsu_op_e op,
      input logic [`LSU_ADDR_W-1:0] addr, input logic [`LSU_DATA_W-1:0] data);
    int idx;
    idx = int'(addr[`LSU_ADDR_W-1:OFF_W]);
    if (op == lsu_pkg::OP_SW) begin
      ref_mem[idx] = data;
    end else if (op == lsu_pkg::OP_SB) begin
      ref_mem[idx][addr[OFF_W-1:0]*8 +: 8] = data[7:0];
    end
    return (op == lsu_pkg::OP_LW) ? ref_mem[idx] : '0;
  endfunction

  // One request offered on a falling edge, recorded if accepted
  task automatic drive_req(input lsu_pkg::lsu_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
      input logic [`LSU_DATA_W-1:0] data, output bit accepted);
    lsu_pkg::done_rpt_t exp;
    @(negedge i_clk);
    i_req_valid = 1'b1;
    i_req_op    = op;
    i_req_addr  = addr;
    i_req_data  = data;
    i_req_tag   = next_tag;
    accepted    = o_req_ready;
    if (accepted) begin
      exp.valid   = 1'b1;
      exp.tag     = next_tag;
      exp.is_load = (op == lsu_pkg::OP_LW);
      exp.data    = ref_access(op, addr, data);
      exp_q.push_back(exp);
      cyc_q.push_back(cyc);
      if (op != lsu_pkg::OP_LW) begin
        touched_q.push_back(addr);
      end
      next_tag = next_tag + 1'b1;
    end
  endtask

  // Retry until accepted, releasing the drain so the buffer empties
  task automatic issue(input lsu_pkg::lsu_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
      input logic [`LSU_DATA_W-1:0] data);
    bit ok;
    drive_req(op, addr, data, ok);
    while (!ok) begin
      i_drain_hold = 1'b0;
      drive_req(op, addr, data, ok);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_req_valid = 1'b0;
    end
  endtask

  task automatic wait_drained();
    i_drain_hold = 1'b0;
    idle(`LSU_STBUF_DEPTH + 2);
  endtask

  task automatic snoop_check(input logic [`LSU_ADDR_W-1:0] addr);
    logic [`LSU_DATA_W-1:0] exp;
    @(negedge i_clk);
    i_req_valid   = 1'b0;
    i_snoop_valid = 1'b1;
    i_snoop_addr  = addr;
    @(negedge i_clk);
    i_snoop_valid = 1'b0;
    exp = ref_mem[int'(addr[`LSU_ADDR_W-1:OFF_W])];
    if (o_snoop_valid !== 1'b1) begin
      n_err++;
      $display("ERROR: at %0t the snoop read of %0h returned no response", $time, addr);
    end else if (o_snoop_data !== exp) begin
      n_err++;
      $display("CHECK FAILED at %0t: o_snoop_data expected %0h got %0h",
               $time, exp, o_snoop_data);
    end
  endtask

  // ------------------------------------------------------------
  // Done report comparison
  // ------------------------------------------------------------
  always @(negedge i_clk) begin : compare_done
    lsu_pkg::done_rpt_t exp;
    int                 exp_cyc;
    if (i_reset_n && o_done_valid) begin
      if (exp_q.size() == 0) begin
        n_err++;
        $display("ERROR: at %0t a done report arrived with no request outstanding", $time);
      end else begin
        exp     = exp_q.pop_front();
        exp_cyc = cyc_q.pop_front();
        if (cyc != exp_cyc + 2) begin
          n_err++;
          $display("CHECK FAILED at %0t: o_done_valid cycle expected %0d got %0d",
                   $time, exp_cyc + 2, cyc);
        end
        if (o_done_tag !== exp.tag) begin
          n_err++;
          $display("CHECK FAILED at %0t: o_done_tag expected %0h got %0h",
                   $time, exp.tag, o_done_tag);
        end
        if (o_done_is_load !== exp.is_load) begin
          n_err++;
          $display("CHECK FAILED at %0t: o_done_is_load expected %0b got %0b",
                   $time, exp.is_load, o_done_is_load);
        end
        if (exp.is_load && (o_done_data !== exp.data)) begin
          n_err++;
          $display("CHECK FAILED at %0t: o_done_data expected %0h got %0h",
                   $time, exp.data, o_done_data);
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles with %0d done reports still missing",
               cyc, exp_q.size());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [31:0]            rnd;
    logic [`LSU_ADDR_W-1:0] a;
    logic [`LSU_DATA_W-1:0] d;
    bit                     ok;
    int                     n;
    for (int i = 0; i < WORDS; i++) begin
      ref_mem[i] = '0;
    end
    i_req_valid   = 1'b0;
    i_req_op      = lsu_pkg::OP_LW;
    i_req_addr    = '0;
    i_req_data    = '0;
    i_req_tag     = '0;
    i_drain_hold  = 1'b0;
    i_snoop_valid = 1'b0;
    i_snoop_addr  = '0;
    @(posedge i_reset_n);
    idle(2);

    // Loads of a freshly cleared cache
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      issue(lsu_pkg::OP_LW, {rnd[`LSU_ADDR_W-1:OFF_W], {OFF_W{1'b0}}}, '0);
    end

    // Forwarding with the drain held
    i_drain_hold = 1'b1;
    issue(lsu_pkg::OP_SW, 8'h10, 32'hdead_beef);
    issue(lsu_pkg::OP_LW, 8'h10, '0);
    issue(lsu_pkg::OP_SW, 8'h14, 32'h1234_5678);
    issue(lsu_pkg::OP_LW, 8'h14, '0);
    wait_drained();

    // Byte lanes merged from buffer and cache
    i_drain_hold = 1'b1;
    issue(lsu_pkg::OP_SB, 8'h20, 32'h0000_00a1);
    issue(lsu_pkg::OP_SB, 8'h22, 32'h0000_00c3);
    issue(lsu_pkg::OP_LW, 8'h20, '0);
    wait_drained();
    i_drain_hold = 1'b1;
    issue(lsu_pkg::OP_SB, 8'h21, 32'h0000_00b2);
    issue(lsu_pkg::OP_SB, 8'h23, 32'h0000_00d4);
    issue(lsu_pkg::OP_LW, 8'h20, '0);
    wait_drained();
    issue(lsu_pkg::OP_LW, 8'h20, '0);

    // Back-pressure from a held drain
    wait_drained();
    i_drain_hold = 1'b1;
    for (int i = 0; i < `LSU_STBUF_DEPTH; i++) begin
      drive_req(lsu_pkg::OP_SW, 8'h30 + 8'(4 * i), $random(seed), ok);
      if (!ok) begin
        n_err++;
        $display("ERROR: at %0t a store was refused while the buffer had space", $time);
      end
    end
    repeat (3) begin
      drive_req(lsu_pkg::OP_SW, 8'h28, 32'h5a5a_0f0f, ok);
      if (ok) begin
        n_err++;
        $display("CHECK FAILED at %0t: o_req_ready expected 0 got 1", $time);
      end
    end
    i_drain_hold = 1'b0;
    n = 0;
    while (!o_req_ready && (n < `LSU_STBUF_DEPTH + 2)) begin
      idle(1);
      n++;
    end
    if (!o_req_ready) begin
      n_err++;
      $display("ERROR: o_req_ready stayed low after the drain hold was released");
    end
    issue(lsu_pkg::OP_SW, 8'h28, 32'h5a5a_0f0f);
    for (int i = 0; i < `LSU_STBUF_DEPTH; i++) begin
      issue(lsu_pkg::OP_LW, 8'h30 + 8'(4 * i), '0);
    end
    issue(lsu_pkg::OP_LW, 8'h28, '0);

    // Snoop reads of every stored address
    wait_drained();
    while (touched_q.size() != 0) begin
      snoop_check(touched_q.pop_front());
    end

    // Random mix over a window of eight words
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      d   = $random(seed);
      a   = 8'h40 | 8'(rnd[4:0]);
      i_drain_hold = (rnd[6:5] == 2'd0);
      case (rnd[10:8])
        3'd0, 3'd1, 3'd2: issue(lsu_pkg::OP_LW, {a[`LSU_ADDR_W-1:OFF_W], 2'b00}, '0);
        3'd3, 3'd4:       issue(lsu_pkg::OP_SW, {a[`LSU_ADDR_W-1:OFF_W], 2'b00}, d);
        3'd5, 3'd6:       issue(lsu_pkg::OP_SB, a, d);
        default: begin
          wait_drained();
          snoop_check(a);
        end
      endcase
    end

    wait_drained();
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(2);
    $display("Errors: %0d check, %0d assertion", n_err, u_lsu_top.u_lsu_assert.fail_count);
    if ((n_err == 0) && (u_lsu_top.u_lsu_assert.fail_count == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
